// File: hw/qdr_sniffer_defines.svh
`ifndef QDR_SNIFFER_DEFINES_SVH
`define QDR_SNIFFER_DEFINES_SVH

// QDR word address width.
`define QDR_ADDR_WIDTH 21

// one burst half; a full QDR word is two halves.
`define QDR_DATA_WIDTH 36

// byte-write bits per burst half.
`define QDR_BW_WIDTH 2

// cycles from a read strobe to the matching data-valid pulse.
`define QDR_LATENCY 6

// config register byte offsets.
`define CFG_CTRL   4'h0
`define CFG_STATUS 4'h4
`define CFG_GRANTS 4'h8

`endif

// File: hw/qdr_sniffer_pkg.sv
`default_nettype none

package qdr_sniffer_pkg;

  // arbiter owner of the QDR command port, one-hot.
  typedef enum logic [3:0] {
    SLAVE         = 4'b0001, // fabric owns the port.
    SLAVE_WAIT    = 4'b0010, // let the fabric command in flight finish.
    BACKDOOR      = 4'b0100, // the single backdoor slot.
    BACKDOOR_WAIT = 4'b1000
  } arb_state_t;

  // AXI4-Lite response codes used by both host ports.
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

endpackage

`default_nettype wire

// File: hw/qdr_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniffer_defines.svh"

// One backdoor QDR command and the read data coming back.
interface qdr_cmd_if;

  logic                           req;   // held until ack.
  logic                           rnw;
  logic [`QDR_ADDR_WIDTH-1:0]     addr;
  logic [2*`QDR_DATA_WIDTH-1:0]   wdata;
  logic [2*`QDR_BW_WIDTH-1:0]     be;
  logic                           ack;   // one cycle, fields are sampled here.
  logic [2*`QDR_DATA_WIDTH-1:0]   rdata;

  modport requester (
    output req, rnw, addr, wdata, be,
    input  ack, rdata
  );

  modport granter (
    input  req, rnw, addr, wdata, be,
    output ack, rdata
  );

endinterface

`default_nettype wire

// File: hw/qdr_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniffer_defines.svh"

module qdr_cfg_regs (
  input  logic                      qdr_clk,
  input  logic                      qdr_rst,
  input  logic [3:0]                cfg_awaddr,
  input  logic                      cfg_awvalid,
  output logic                      cfg_awready,
  input  logic [31:0]               cfg_wdata,
  input  logic                      cfg_wvalid,
  output logic                      cfg_wready,
  output qdr_sniffer_pkg::axi_resp_t cfg_bresp,
  output logic                      cfg_bvalid,
  input  logic                      cfg_bready,
  input  logic [3:0]                cfg_araddr,
  input  logic                      cfg_arvalid,
  output logic                      cfg_arready,
  output logic [31:0]               cfg_rdata,
  output qdr_sniffer_pkg::axi_resp_t cfg_rresp,
  output logic                      cfg_rvalid,
  input  logic                      cfg_rready,
  input  logic                      phy_rdy,
  input  logic                      cal_fail,
  input  logic                      grant_pulse,
  output logic                      qdr_reset,
  output logic                      backdoor_en
);

  logic [1:0]  ctrl_q;     // bit 0 is the QDR reset, bit 1 the backdoor enable.
  logic [1:0]  sync_q1;
  logic [1:0]  sync_q2;
  logic [31:0] grant_cnt;
  logic        idle;
  logic        wr_go;
  logic        rd_go;

  // one transaction at a time, a write wins over a read in the same cycle.
  assign idle  = !cfg_bvalid && !cfg_rvalid;
  assign wr_go = idle && cfg_awvalid && cfg_wvalid;
  assign rd_go = idle && cfg_arvalid && !wr_go;

  assign cfg_awready = idle;
  assign cfg_wready  = idle;
  assign cfg_arready = idle && !(cfg_awvalid && cfg_wvalid);

  assign qdr_reset   = ctrl_q[0];
  assign backdoor_en = ctrl_q[1];

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      sync_q1 <= 2'b00;
      sync_q2 <= 2'b00;
    end else begin
      sync_q1 <= {cal_fail, phy_rdy}; // status bits come from the PHY clock domain.
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      ctrl_q     <= 2'b10;
      grant_cnt  <= 32'd0;
      cfg_bvalid <= 1'b0;
      cfg_rvalid <= 1'b0;
    end else begin
      if (grant_pulse) grant_cnt <= grant_cnt + 32'd1;
      if (cfg_bvalid && cfg_bready) cfg_bvalid <= 1'b0;
      if (cfg_rvalid && cfg_rready) cfg_rvalid <= 1'b0;
      if (wr_go) begin
        cfg_bvalid <= 1'b1;
        if (cfg_awaddr == `CFG_CTRL) ctrl_q <= cfg_wdata[1:0];
      end
      if (rd_go) cfg_rvalid <= 1'b1;
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (wr_go) begin
      case (cfg_awaddr)
        `CFG_CTRL, `CFG_STATUS, `CFG_GRANTS: cfg_bresp <= qdr_sniffer_pkg::OKAY;
        default:                             cfg_bresp <= qdr_sniffer_pkg::SLVERR;
      endcase
    end
    if (rd_go) begin
      cfg_rresp <= qdr_sniffer_pkg::OKAY;
      case (cfg_araddr)
        `CFG_CTRL:   cfg_rdata <= {30'd0, ctrl_q};
        `CFG_STATUS: cfg_rdata <= {30'd0, sync_q2};
        `CFG_GRANTS: cfg_rdata <= grant_cnt;
        default: begin
          cfg_rdata <= 32'd0;
          cfg_rresp <= qdr_sniffer_pkg::SLVERR;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/qdr_backdoor_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniffer_defines.svh"

module qdr_backdoor_port (
  input  logic                       qdr_clk,
  input  logic                       qdr_rst,
  input  logic [31:0]                bd_awaddr,
  input  logic                       bd_awvalid,
  output logic                       bd_awready,
  input  logic [31:0]                bd_wdata,
  input  logic [3:0]                 bd_wstrb,
  input  logic                       bd_wvalid,
  output logic                       bd_wready,
  output qdr_sniffer_pkg::axi_resp_t bd_bresp,
  output logic                       bd_bvalid,
  input  logic                       bd_bready,
  input  logic [31:0]                bd_araddr,
  input  logic                       bd_arvalid,
  output logic                       bd_arready,
  output logic [31:0]                bd_rdata,
  output qdr_sniffer_pkg::axi_resp_t bd_rresp,
  output logic                       bd_rvalid,
  input  logic                       bd_rready,
  input  logic                       backdoor_en,
  qdr_cmd_if.requester               cmd
);

  localparam int CNT_W = $clog2(`QDR_LATENCY + 1);

  logic [CNT_W-1:0]           lat_cnt;
  logic                       rd_busy;
  logic                       rd_half;   // byte address bit 2 of the read in flight.
  logic                       idle;
  logic                       wr_go;
  logic                       rd_go;
  logic [`QDR_DATA_WIDTH-1:0] host_half;
  logic [`QDR_BW_WIDTH-1:0]   host_be;

  assign idle  = !cmd.req && !rd_busy && !bd_bvalid && !bd_rvalid;
  assign wr_go = idle && bd_awvalid && bd_wvalid;
  assign rd_go = idle && bd_arvalid && !wr_go;

  assign bd_awready = idle;
  assign bd_wready  = idle;
  assign bd_arready = idle && !(bd_awvalid && bd_wvalid);

  // The host word sits in the low bits of a half, the spare top bits stay zero.
  assign host_half = {{(`QDR_DATA_WIDTH - 32){1'b0}}, bd_wdata};
  assign host_be   = {|bd_wstrb[3:2], |bd_wstrb[1:0]};

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      cmd.req   <= 1'b0;
      rd_busy   <= 1'b0;
      lat_cnt   <= '0;
      bd_bvalid <= 1'b0;
      bd_rvalid <= 1'b0;
    end else begin
      if (bd_bvalid && bd_bready) bd_bvalid <= 1'b0;
      if (bd_rvalid && bd_rready) bd_rvalid <= 1'b0;
      if (wr_go) begin
        if (backdoor_en) cmd.req <= 1'b1;
        else bd_bvalid <= 1'b1; // disabled, answer at once with an error.
      end
      if (rd_go) begin
        if (backdoor_en) cmd.req <= 1'b1;
        else bd_rvalid <= 1'b1;
      end
      if (cmd.req && cmd.ack) begin
        cmd.req <= 1'b0;
        if (cmd.rnw) begin
          rd_busy <= 1'b1;
          lat_cnt <= CNT_W'(`QDR_LATENCY - 1);
        end else begin
          bd_bvalid <= 1'b1;
        end
      end
      // The read data is on the bus in the cycle the count reaches zero.
      if (rd_busy) begin
        if (lat_cnt == '0) begin
          rd_busy   <= 1'b0;
          bd_rvalid <= 1'b1;
        end else begin
          lat_cnt <= lat_cnt - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (wr_go) begin
      cmd.rnw  <= 1'b0;
      cmd.addr <= bd_awaddr[`QDR_ADDR_WIDTH+2:3];
      if (bd_awaddr[2]) begin
        cmd.wdata <= {host_half, {`QDR_DATA_WIDTH{1'b0}}};
        cmd.be    <= {host_be, {`QDR_BW_WIDTH{1'b0}}};
      end else begin
        cmd.wdata <= {{`QDR_DATA_WIDTH{1'b0}}, host_half};
        cmd.be    <= {{`QDR_BW_WIDTH{1'b0}}, host_be};
      end
      bd_bresp <= backdoor_en ? qdr_sniffer_pkg::OKAY : qdr_sniffer_pkg::SLVERR;
    end
    if (rd_go) begin
      cmd.rnw  <= 1'b1;
      cmd.addr <= bd_araddr[`QDR_ADDR_WIDTH+2:3];
      cmd.be   <= '0;
      rd_half  <= bd_araddr[2];
      bd_rresp <= backdoor_en ? qdr_sniffer_pkg::OKAY : qdr_sniffer_pkg::SLVERR;
      if (!backdoor_en) bd_rdata <= 32'd0;
    end
    if (rd_busy && lat_cnt == '0) begin
      bd_rdata <= rd_half ? cmd.rdata[`QDR_DATA_WIDTH+31:`QDR_DATA_WIDTH]
                          : cmd.rdata[31:0];
    end
  end

endmodule

`default_nettype wire

// File: hw/qdr_sniffer_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniffer_defines.svh"

module qdr_sniffer_arb (
  input  logic                           qdr_clk,
  input  logic                           qdr_rst,
  qdr_cmd_if.granter                     cmd,
  input  logic [31:0]                    slave_addr,
  input  logic                           slave_wr_strb,
  input  logic                           slave_rd_strb,
  input  logic [2*`QDR_DATA_WIDTH-1:0]   slave_wr_data,
  input  logic [2*`QDR_BW_WIDTH-1:0]     slave_wr_be,
  output logic                           slave_ack,
  output logic                           grant_pulse,
  output logic [`QDR_ADDR_WIDTH-1:0]     master_addr,
  output logic                           master_wr_strb,
  output logic                           master_rd_strb,
  output logic [2*`QDR_DATA_WIDTH-1:0]   master_wr_data,
  output logic [2*`QDR_BW_WIDTH-1:0]     master_wr_be,
  input  logic [2*`QDR_DATA_WIDTH-1:0]   master_rd_data
);

  qdr_sniffer_pkg::arb_state_t state;
  logic                        slave_busy;
  logic                        fabric_side;

  assign slave_busy = slave_wr_strb || slave_rd_strb;

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      state <= qdr_sniffer_pkg::SLAVE;
    end else begin
      case (state)
        qdr_sniffer_pkg::SLAVE: begin
          if (cmd.req) begin
            // a fabric strobe seen here is still issued, so give it one cycle.
            state <= slave_busy ? qdr_sniffer_pkg::SLAVE_WAIT : qdr_sniffer_pkg::BACKDOOR;
          end
        end
        qdr_sniffer_pkg::SLAVE_WAIT:    state <= qdr_sniffer_pkg::BACKDOOR;
        qdr_sniffer_pkg::BACKDOOR:      state <= qdr_sniffer_pkg::BACKDOOR_WAIT;
        qdr_sniffer_pkg::BACKDOOR_WAIT: state <= qdr_sniffer_pkg::SLAVE;
        default:                        state <= qdr_sniffer_pkg::SLAVE;
      endcase
    end
  end

  assign slave_ack   = (state == qdr_sniffer_pkg::SLAVE);
  assign cmd.ack     = (state == qdr_sniffer_pkg::BACKDOOR); // the one backdoor slot.
  assign grant_pulse = cmd.ack;

  // Write data stays on the fabric until the backdoor slot is near.
  assign fabric_side = (state == qdr_sniffer_pkg::SLAVE) ||
                       (state == qdr_sniffer_pkg::SLAVE_WAIT);

  assign master_wr_strb = (slave_wr_strb && slave_ack) || (cmd.req && !cmd.rnw && cmd.ack);
  assign master_rd_strb = (slave_rd_strb && slave_ack) || (cmd.req && cmd.rnw && cmd.ack);
  assign master_addr    = slave_ack ? slave_addr[`QDR_ADDR_WIDTH-1:0] : cmd.addr;
  assign master_wr_data = fabric_side ? slave_wr_data : cmd.wdata;
  assign master_wr_be   = fabric_side ? slave_wr_be : cmd.be;

  assign cmd.rdata = master_rd_data;

endmodule

`default_nettype wire

// File: hw/qdr_sniffer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniffer_defines.svh"

module qdr_sniffer_top (
  input  logic                           qdr_clk,
  input  logic                           qdr_rst,
  input  logic [3:0]                     cfg_awaddr,
  input  logic                           cfg_awvalid,
  output logic                           cfg_awready,
  input  logic [31:0]                    cfg_wdata,
  input  logic                           cfg_wvalid,
  output logic                           cfg_wready,
  output qdr_sniffer_pkg::axi_resp_t     cfg_bresp,
  output logic                           cfg_bvalid,
  input  logic                           cfg_bready,
  input  logic [3:0]                     cfg_araddr,
  input  logic                           cfg_arvalid,
  output logic                           cfg_arready,
  output logic [31:0]                    cfg_rdata,
  output qdr_sniffer_pkg::axi_resp_t     cfg_rresp,
  output logic                           cfg_rvalid,
  input  logic                           cfg_rready,
  input  logic [31:0]                    bd_awaddr,
  input  logic                           bd_awvalid,
  output logic                           bd_awready,
  input  logic [31:0]                    bd_wdata,
  input  logic [3:0]                     bd_wstrb,
  input  logic                           bd_wvalid,
  output logic                           bd_wready,
  output qdr_sniffer_pkg::axi_resp_t     bd_bresp,
  output logic                           bd_bvalid,
  input  logic                           bd_bready,
  input  logic [31:0]                    bd_araddr,
  input  logic                           bd_arvalid,
  output logic                           bd_arready,
  output logic [31:0]                    bd_rdata,
  output qdr_sniffer_pkg::axi_resp_t     bd_rresp,
  output logic                           bd_rvalid,
  input  logic                           bd_rready,
  input  logic [31:0]                    slave_addr,
  input  logic                           slave_wr_strb,
  input  logic                           slave_rd_strb,
  input  logic [2*`QDR_DATA_WIDTH-1:0]   slave_wr_data,
  input  logic [2*`QDR_BW_WIDTH-1:0]     slave_wr_be,
  output logic                           slave_ack,
  output logic [2*`QDR_DATA_WIDTH-1:0]   slave_rd_data,
  output logic                           slave_rd_dvld,
  output logic [`QDR_ADDR_WIDTH-1:0]     master_addr,
  output logic                           master_wr_strb,
  output logic                           master_rd_strb,
  output logic [2*`QDR_DATA_WIDTH-1:0]   master_wr_data,
  output logic [2*`QDR_BW_WIDTH-1:0]     master_wr_be,
  input  logic [2*`QDR_DATA_WIDTH-1:0]   master_rd_data,
  input  logic                           master_rd_dvld,
  input  logic                           phy_rdy,
  input  logic                           cal_fail,
  output logic                           qdr_reset
);

  logic grant_pulse;
  logic backdoor_en;

  qdr_cmd_if cmd ();

  // Port names match the top level, so the blocks connect by name.
  qdr_cfg_regs qdr_cfg_regs_i (.*);

  qdr_backdoor_port qdr_backdoor_port_i (.*);

  qdr_sniffer_arb qdr_sniffer_arb_i (.*);

  // fabric reads come straight back from the controller.
  assign slave_rd_data = master_rd_data;
  assign slave_rd_dvld = master_rd_dvld;

endmodule

`default_nettype wire

// File: tests/qdr_mem_stub.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniffer_defines.svh"

// QDR controller model with sparse storage and a fixed read latency.
module qdr_mem_stub (
  input  logic                         qdr_clk,
  input  logic                         qdr_rst,
  input  logic [`QDR_ADDR_WIDTH-1:0]   addr,
  input  logic                         wr_strb,
  input  logic                         rd_strb,
  input  logic [2*`QDR_DATA_WIDTH-1:0] wr_data,
  input  logic [2*`QDR_BW_WIDTH-1:0]   wr_be,
  output logic [2*`QDR_DATA_WIDTH-1:0] rd_data,
  output logic                         rd_dvld
);

  localparam int LAT = `QDR_LATENCY;
  localparam int SEG = `QDR_DATA_WIDTH / `QDR_BW_WIDTH; // bits under one byte-write bit.

  logic [2*`QDR_DATA_WIDTH-1:0] mem [logic [`QDR_ADDR_WIDTH-1:0]];
  logic [2*`QDR_DATA_WIDTH-1:0] data_pipe [LAT];
  logic [LAT-1:0]               vld_pipe;
  logic [2*`QDR_DATA_WIDTH-1:0] word;

  always @(posedge qdr_clk) begin
    word = mem.exists(addr) ? mem[addr] : '0;
    if (wr_strb) begin
      for (int k = 0; k < 2*`QDR_BW_WIDTH; k++) begin
        if (wr_be[k]) word[SEG*k +: SEG] = wr_data[SEG*k +: SEG];
      end
      mem[addr] = word;
    end
    // several reads can be in flight, one per stage.
    for (int i = LAT-1; i > 0; i--) data_pipe[i] <= data_pipe[i-1];
    data_pipe[0] <= word;
    if (qdr_rst) vld_pipe <= '0;
    else vld_pipe <= {vld_pipe[LAT-2:0], rd_strb};
  end

  assign rd_data = data_pipe[LAT-1];
  assign rd_dvld = vld_pipe[LAT-1];

endmodule

`default_nettype wire

// File: tests/qdr_sniffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniffer_defines.svh"

module qdr_sniffer_tb;

  localparam int W = 2*`QDR_DATA_WIDTH;
  localparam int N_FAB = 40;
  localparam int N_BD = 30;
  localparam int N_MIX_FAB = 60;
  localparam int N_MIX_BD = 30;
  localparam int TOTAL_TXN = 2*N_FAB + 3*N_BD + N_MIX_FAB + N_MIX_BD + 30;

  logic qdr_clk, qdr_rst;
  logic [3:0] cfg_awaddr, cfg_araddr;
  logic cfg_awvalid, cfg_awready, cfg_wvalid, cfg_wready, cfg_bvalid, cfg_bready;
  logic cfg_arvalid, cfg_arready, cfg_rvalid, cfg_rready;
  logic [31:0] cfg_wdata, cfg_rdata;
  qdr_sniffer_pkg::axi_resp_t cfg_bresp, cfg_rresp, bd_bresp, bd_rresp;
  logic [31:0] bd_awaddr, bd_wdata, bd_araddr, bd_rdata;
  logic [3:0] bd_wstrb;
  logic bd_awvalid, bd_awready, bd_wvalid, bd_wready, bd_bvalid, bd_bready;
  logic bd_arvalid, bd_arready, bd_rvalid, bd_rready;
  logic [31:0] slave_addr;
  logic slave_wr_strb, slave_rd_strb, slave_ack, slave_rd_dvld;
  logic [W-1:0] slave_wr_data, slave_rd_data, master_wr_data, master_rd_data;
  logic [3:0] slave_wr_be, master_wr_be;
  logic [`QDR_ADDR_WIDTH-1:0] master_addr;
  logic master_wr_strb, master_rd_strb, master_rd_dvld;
  logic phy_rdy, cal_fail, qdr_reset;

  logic [W-1:0] model_mem [int];
  logic [W-1:0] exp_data [$];    // fabric read words, in issue order.
  int exp_cyc [$];               // cycle in which each of them must show up.
  int cyc, errors, low_run, bd_grants;
  bit bd_enabled;
  logic [31:0] rd_word;
  qdr_sniffer_pkg::axi_resp_t resp;

  qdr_sniffer_top qdr_sniffer_top_i (.*);

  qdr_mem_stub qdr_mem_stub_i (
    .qdr_clk(qdr_clk), .qdr_rst(qdr_rst), .addr(master_addr),
    .wr_strb(master_wr_strb), .rd_strb(master_rd_strb), .wr_data(master_wr_data),
    .wr_be(master_wr_be), .rd_data(master_rd_data), .rd_dvld(master_rd_dvld)
  );

  initial begin
    qdr_clk = 1'b0;
    forever #2 qdr_clk = ~qdr_clk;
  end

  always @(posedge qdr_clk) cyc <= cyc + 1;

  task automatic check(input string name, input logic [W-1:0] act, input logic [W-1:0] exp);
    if (act !== exp) begin
      errors++;
      $display("ERROR at %0t: %s actual %h expected %h", $time, name, act, exp);
    end
  endtask

  function automatic logic [W-1:0] model_read(input int w);
    return model_mem.exists(w) ? model_mem[w] : '0;
  endfunction

  // each byte-write bit covers 18 bits of the 72-bit word.
  function automatic void model_write(input int w, input logic [W-1:0] d, input logic [3:0] be);
    logic [W-1:0] v;
    v = model_read(w);
    for (int k = 0; k < 4; k++) if (be[k]) v[18*k +: 18] = d[18*k +: 18];
    model_mem[w] = v;
  endfunction

  function automatic logic [W-1:0] rand72();
    return {8'($urandom), $urandom, $urandom};
  endfunction

  // slave_ack only moves on a rising edge, so its value here holds for the next edge.
  always @(negedge qdr_clk) begin
    if (!qdr_rst) begin
      low_run = slave_ack ? 0 : low_run + 1;
      if (low_run > 3) begin
        errors++;
        $display("slave_ack stayed low for more than 3 cycles at %0t", $time);
      end
      if (exp_cyc.size() != 0 && exp_cyc[0] == cyc) begin
        if (!slave_rd_dvld) begin
          errors++;
          $display("fabric read data did not arrive on time at %0t", $time);
        end else begin
          check("slave_rd_data", slave_rd_data, exp_data[0]);
        end
        void'(exp_cyc.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  task automatic fabric_cmd(input bit wr, input int w, input logic [W-1:0] d,
                            input logic [3:0] be);
    slave_addr = 32'(w);
    slave_wr_data = d;
    slave_wr_be = be;
    slave_wr_strb = wr;
    slave_rd_strb = !wr;
    while (!slave_ack) @(negedge qdr_clk); // command held until accepted.
    if (wr) model_write(w, d, be);
    else begin
      exp_data.push_back(model_read(w));
      exp_cyc.push_back(cyc + `QDR_LATENCY);
    end
    @(negedge qdr_clk);
    slave_wr_strb = 1'b0;
    slave_rd_strb = 1'b0;
  endtask

  task automatic bd_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s,
                          output qdr_sniffer_pkg::axi_resp_t r);
    bd_awaddr = a;
    bd_wdata = d;
    bd_wstrb = s;
    bd_awvalid = 1'b1;
    bd_wvalid = 1'b1;
    while (!(bd_awready && bd_wready)) @(negedge qdr_clk);
    @(negedge qdr_clk);
    bd_awvalid = 1'b0;
    bd_wvalid = 1'b0;
    while (!bd_bvalid) @(negedge qdr_clk);
    r = bd_bresp;
  endtask

  task automatic bd_read(input logic [31:0] a, output logic [31:0] d,
                         output qdr_sniffer_pkg::axi_resp_t r);
    bd_araddr = a;
    bd_arvalid = 1'b1;
    while (!bd_arready) @(negedge qdr_clk);
    @(negedge qdr_clk);
    bd_arvalid = 1'b0;
    while (!bd_rvalid) @(negedge qdr_clk);
    d = bd_rdata;
    r = bd_rresp;
  endtask

  task automatic cfg_write(input logic [3:0] a, input logic [31:0] d,
                           output qdr_sniffer_pkg::axi_resp_t r);
    cfg_awaddr = a;
    cfg_wdata = d;
    cfg_awvalid = 1'b1;
    cfg_wvalid = 1'b1;
    while (!(cfg_awready && cfg_wready)) @(negedge qdr_clk);
    @(negedge qdr_clk);
    cfg_awvalid = 1'b0;
    cfg_wvalid = 1'b0;
    while (!cfg_bvalid) @(negedge qdr_clk);
    r = cfg_bresp;
  endtask

  task automatic cfg_read(input logic [3:0] a, output logic [31:0] d,
                          output qdr_sniffer_pkg::axi_resp_t r);
    cfg_araddr = a;
    cfg_arvalid = 1'b1;
    while (!cfg_arready) @(negedge qdr_clk);
    @(negedge qdr_clk);
    cfg_arvalid = 1'b0;
    while (!cfg_rvalid) @(negedge qdr_clk);
    d = cfg_rdata;
    r = cfg_rresp;
  endtask

  // host word lands in the low 32 bits of one half, the half's top 4 bits become zero.
  task automatic backdoor_write_op(input int w, input bit half, input logic [31:0] d,
                                   input logic [3:0] strb);
    logic [35:0] h;
    logic [1:0] be2;
    qdr_sniffer_pkg::axi_resp_t r;
    h = {4'd0, d};
    be2 = {|strb[3:2], |strb[1:0]};
    bd_write({w[28:0], half, 2'b00}, d, strb, r);
    if (bd_enabled) begin
      check("bd_bresp", r, qdr_sniffer_pkg::OKAY);
      model_write(w, half ? {h, 36'd0} : {36'd0, h}, half ? {be2, 2'b00} : {2'b00, be2});
      bd_grants++;
    end else begin
      check("bd_bresp", r, qdr_sniffer_pkg::SLVERR);
    end
  endtask

  task automatic backdoor_read_op(input int w, input bit half);
    logic [31:0] d;
    logic [W-1:0] v;
    qdr_sniffer_pkg::axi_resp_t r;
    bd_read({w[28:0], half, 2'b00}, d, r);
    v = model_read(w);
    if (bd_enabled) begin
      check("bd_rresp", r, qdr_sniffer_pkg::OKAY);
      check("bd_rdata", d, half ? v[67:36] : v[31:0]);
      bd_grants++;
    end else begin
      check("bd_rresp", r, qdr_sniffer_pkg::SLVERR);
    end
  endtask

  task automatic wait_reads_done();
    while (exp_cyc.size() != 0) @(negedge qdr_clk);
  endtask

  initial begin
    repeat (TOTAL_TXN*40 + 200) @(posedge qdr_clk);
    $display("watchdog expired before the tests finished");
    $display("simulation done, errors: %0d", errors + 1);
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(99));
    {cfg_awaddr, cfg_awvalid, cfg_wdata, cfg_wvalid, cfg_araddr, cfg_arvalid} = '0;
    {bd_awaddr, bd_awvalid, bd_wdata, bd_wstrb, bd_wvalid, bd_araddr, bd_arvalid} = '0;
    {slave_addr, slave_wr_strb, slave_rd_strb, slave_wr_data, slave_wr_be} = '0;
    {phy_rdy, cal_fail} = 2'b00;
    cfg_bready = 1'b1;
    cfg_rready = 1'b1;
    bd_bready = 1'b1;
    bd_rready = 1'b1;
    {cyc, errors, low_run, bd_grants} = '0;
    bd_enabled = 1'b1;
    qdr_rst = 1'b1;
    repeat (2) @(posedge qdr_clk);
    @(negedge qdr_clk);
    qdr_rst = 1'b0;

    // fabric writes, then a run of back-to-back reads.
    for (int i = 0; i < N_FAB; i++) fabric_cmd(1'b1, $urandom_range(0, 15), rand72(), 4'($urandom));
    for (int i = 0; i < N_FAB; i++) fabric_cmd(1'b0, $urandom_range(0, 15), '0, 4'h0);
    wait_reads_done();

    // backdoor halves, read back by both paths.
    for (int i = 0; i < N_BD; i++) begin
      int w;
      bit half;
      w = 64 + $urandom_range(0, 15);
      half = 1'($urandom);
      backdoor_write_op(w, half, $urandom, 4'($urandom));
      backdoor_read_op(w, 1'($urandom));
      fabric_cmd(1'b0, w, '0, 4'h0);
    end
    wait_reads_done();

    // both paths at once on separate words.
    fork
      for (int i = 0; i < N_MIX_FAB; i++) begin
        fabric_cmd(1'($urandom), $urandom_range(0, 63), rand72(), 4'($urandom));
        repeat ($urandom_range(0, 2)) @(negedge qdr_clk);
      end
      for (int i = 0; i < N_MIX_BD; i++) begin
        if ($urandom_range(0, 1)) backdoor_write_op(128 + $urandom_range(0, 15), 1'($urandom),
                                                   $urandom, 4'($urandom));
        else backdoor_read_op(128 + $urandom_range(0, 15), 1'($urandom));
      end
    join
    wait_reads_done();

    // config registers.
    cfg_write(`CFG_CTRL, 32'h3, resp);
    check("qdr_reset", qdr_reset, 1'b1);
    cfg_write(`CFG_CTRL, 32'h2, resp);
    check("qdr_reset", qdr_reset, 1'b0);
    cfg_read(`CFG_CTRL, rd_word, resp);
    check("cfg_rdata ctrl", rd_word, 32'h2);
    for (int p = 0; p < 4; p++) begin
      phy_rdy = p[0];
      cal_fail = p[1];
      repeat (4) @(negedge qdr_clk);
      cfg_read(`CFG_STATUS, rd_word, resp);
      check("cfg_rdata status", rd_word, 32'(p));
      check("cfg_rresp status", resp, qdr_sniffer_pkg::OKAY);
    end
    cfg_read(4'hC, rd_word, resp);
    check("cfg_rresp unmapped", resp, qdr_sniffer_pkg::SLVERR);
    cfg_write(4'hC, 32'h1, resp);
    check("cfg_bresp unmapped", resp, qdr_sniffer_pkg::SLVERR);

    // backdoor disabled, memory must stay as it was.
    cfg_write(`CFG_CTRL, 32'h0, resp);
    bd_enabled = 1'b0;
    backdoor_write_op(70, 1'b0, 32'hdeadbeef, 4'hf);
    backdoor_write_op(70, 1'b1, 32'hcafef00d, 4'hf);
    backdoor_read_op(70, 1'b0);
    fabric_cmd(1'b0, 70, '0, 4'h0);
    wait_reads_done();
    cfg_write(`CFG_CTRL, 32'h2, resp);
    bd_enabled = 1'b1;
    cfg_read(`CFG_GRANTS, rd_word, resp);
    check("cfg_rdata grants", rd_word, 32'(bd_grants));

    $display("simulation done, errors: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/qdr_sniffer_pkg.sv
hw/qdr_cmd_if.sv
hw/qdr_cfg_regs.sv
hw/qdr_backdoor_port.sv
hw/qdr_sniffer_arb.sv
hw/qdr_sniffer_top.sv
tests/qdr_mem_stub.sv
tests/qdr_sniffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; a fail message in the log fails the run.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f flist.f --top-module qdr_sniffer_tb \
  -o qdr_sniffer_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/qdr_sniffer_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0
